// ==== rtl/modSquarePkg.sv ====
// modular squaring package
// shared widths, data types, the fixed modulus and the fold-table function

package modSquarePkg;

   localparam int limbWidth    = 8;
   localparam int residueWidth = 2 * limbWidth;

   typedef logic [limbWidth-1:0]      limbT;
   typedef logic [residueWidth-1:0]   residueT;
   typedef logic [2*residueWidth-1:0] productT;

   // low product half plus two table entries, always below 4N
   typedef logic [residueWidth+1:0]   foldSumT;

   typedef logic [7:0]                countT;

   // prime with the top bit set, so 2^16 < 2N
   localparam residueT modulusN = 16'd65521;

   // a fold sum below 4N needs at most three subtractions
   localparam int maxCorrections = 3;

   // ----------------------------------------------------------
   // sequencer states
   // ----------------------------------------------------------
   typedef enum logic [1:0] {
      idleS,
      squareS,
      reduceS,
      doneS
   } seqStateT;

   // ----------------------------------------------------------
   // fold table entry
   // ----------------------------------------------------------
   // residue of b * 2^(16 + 8p), p is the byte position above the low half
   function automatic residueT foldEntry(input limbT b, input int p);
      longint unsigned weighted;
      weighted = 64'(b) << (residueWidth + limbWidth * p);
      return residueT'(weighted % modulusN);
   endfunction

endpackage

// ==== rtl/limbSquarer.sv ====
// limb squarer
// two-stage pipelined 16-bit squarer built from 8-bit limb partial products

`timescale 1ns/10ps

module limbSquarer (
   input  logic                  clk_sq,
   input  logic                  reset_sq,
   input  logic                  squareStart,
   input  modSquarePkg::residueT squareIn,
   output logic                  productValid,
   output modSquarePkg::productT product
);

   import modSquarePkg::*;

   limbT                   lowLimb;
   limbT                   highLimb;
   logic [2*limbWidth-1:0] crossProd;
   logic [2*limbWidth-1:0] lowSq;
   logic [2*limbWidth-1:0] highSq;
   logic [2*limbWidth:0]   crossDbl;
   logic                   stageValid;

   assign lowLimb   = squareIn[limbWidth-1:0];
   assign highLimb  = squareIn[2*limbWidth-1:limbWidth];
   assign crossProd = lowLimb * highLimb;

   // stage one: the three distinct partial products
   always_ff @(posedge clk_sq)
   begin
      lowSq    <= lowLimb * lowLimb;
      highSq   <= highLimb * highLimb;
      crossDbl <= {crossProd, 1'b0};
   end

   // stage two: align by limb position and sum
   always_ff @(posedge clk_sq)
   begin
      product <= productT'(lowSq)
               + (productT'(crossDbl) << limbWidth)
               + (productT'(highSq) << (2 * limbWidth));
   end

   always_ff @(posedge clk_sq)
   begin
      if (reset_sq)
      begin
         stageValid   <= 1'b0;
         productValid <= 1'b0;
      end
      else
      begin
         stageValid   <= squareStart;
         productValid <= stageValid;
      end
   end

endmodule

// ==== rtl/foldReducer.sv ====
// fold reducer
// folds the upper product bytes through residue tables, then subtracts N
// until the value is fully reduced

`timescale 1ns/10ps

module foldReducer (
   input  logic                  clk_sq,
   input  logic                  reset_sq,
   input  logic                  productValid,
   input  modSquarePkg::productT product,
   output logic                  residueValid,
   output modSquarePkg::residueT residue
);

   import modSquarePkg::*;

   localparam int romDepth = 2 ** limbWidth;

   residueT    foldRomLow  [romDepth];
   residueT    foldRomHigh [romDepth];
   limbT       byteLow;
   limbT       byteHigh;
   foldSumT    foldSum;
   logic       active;
   logic [1:0] corrSteps;
   logic       belowN;

   // ----------------------------------------------------------
   // residue tables for product bytes 2 and 3
   // ----------------------------------------------------------
   for (genvar b = 0; b < romDepth; b++)
   begin : romGen
      assign foldRomLow[b]  = foldEntry(limbT'(b), 0);
      assign foldRomHigh[b] = foldEntry(limbT'(b), 1);
   end

   assign byteLow  = product[residueWidth +: limbWidth];
   assign byteHigh = product[residueWidth+limbWidth +: limbWidth];

   assign belowN = (foldSum < foldSumT'(modulusN));

   // the step bound is never reached for a fold sum below 4N
   assign residueValid = active && (belowN || corrSteps == 2'(maxCorrections));
   assign residue      = foldSum[residueWidth-1:0];

   // ----------------------------------------------------------
   // fold and correction datapath
   // ----------------------------------------------------------
   always_ff @(posedge clk_sq)
   begin
      if (productValid)
         foldSum <= foldSumT'(product[residueWidth-1:0])
                  + foldSumT'(foldRomLow[byteLow])
                  + foldSumT'(foldRomHigh[byteHigh]);
      else if (active && !residueValid)
         foldSum <= foldSum - foldSumT'(modulusN);
   end

   always_ff @(posedge clk_sq)
   begin
      if (reset_sq)
      begin
         active    <= 1'b0;
         corrSteps <= 2'd0;
      end
      else if (productValid)
      begin
         active    <= 1'b1;
         corrSteps <= 2'd0;
      end
      else if (residueValid)
         active <= 1'b0;
      else if (active)
         corrSteps <= corrSteps + 2'd1;
   end

endmodule

// ==== rtl/squareSequencer.sv ====
// squaring sequencer
// holds the working operand and the remaining round count, issues one
// squaring per round and signals the finished job

`timescale 1ns/10ps

module squareSequencer (
   input  logic                  clk_sq,
   input  logic                  reset_sq,
   input  logic                  start,
   input  modSquarePkg::residueT operand,
   input  modSquarePkg::countT   squarings,
   input  logic                  residueValid,
   input  modSquarePkg::residueT residue,
   output logic                  squareStart,
   output modSquarePkg::residueT squareIn,
   output logic                  busy,
   output logic                  done,
   output modSquarePkg::residueT result
);

   import modSquarePkg::*;

   seqStateT state;
   seqStateT nextState;
   residueT  opReg;
   countT    roundsLeft;
   logic     accept;
   logic     roundDone;
   logic     lastRound;

   // starts are only taken in idle
   assign accept    = (state == idleS) && start;
   assign roundDone = (state == reduceS) && residueValid;
   assign lastRound = (roundsLeft == countT'(1));

   // ----------------------------------------------------------
   // job FSM
   // ----------------------------------------------------------
   always_comb
   begin
      nextState = state;
      case (state)
         idleS:
            if (start)
               nextState = (squarings == '0) ? doneS : squareS;
         squareS:
            nextState = reduceS;
         reduceS:
            if (residueValid)
               nextState = lastRound ? doneS : squareS;
         doneS:
            nextState = idleS;
         default:
            nextState = idleS;
      endcase
   end

   always_ff @(posedge clk_sq)
   begin
      if (reset_sq)
         state <= idleS;
      else
         state <= nextState;
   end

   always_ff @(posedge clk_sq)
   begin
      if (reset_sq)
         roundsLeft <= '0;
      else if (accept)
         roundsLeft <= squarings;
      else if (roundDone)
         roundsLeft <= roundsLeft - countT'(1);
   end

   // operand register, reloaded with each reduced square
   always_ff @(posedge clk_sq)
   begin
      if (accept)
         opReg <= operand;
      else if (roundDone)
         opReg <= residue;
   end

   assign squareStart = (state == squareS);
   assign squareIn    = opReg;
   assign busy        = (state != idleS);
   assign done        = (state == doneS);
   assign result      = opReg;

endmodule

// ==== rtl/modSquareTop.sv ====
// modular squaring engine
// raises an operand to the power 2^count modulo N by repeated squaring

`timescale 1ns/10ps

module modSquareTop (
   input  logic                  clk_sq,
   input  logic                  reset_sq,
   input  logic                  start,
   input  modSquarePkg::residueT operand,
   input  modSquarePkg::countT   squarings,
   output logic                  busy,
   output logic                  done,
   output modSquarePkg::residueT result
);

   import modSquarePkg::*;

   logic    squareStart;
   residueT squareIn;
   logic    productValid;
   productT product;
   logic    residueValid;
   residueT residue;

   squareSequencer squareSequencer_inst (
      .clk_sq       (clk_sq),
      .reset_sq     (reset_sq),
      .start        (start),
      .operand      (operand),
      .squarings    (squarings),
      .residueValid (residueValid),
      .residue      (residue),
      .squareStart  (squareStart),
      .squareIn     (squareIn),
      .busy         (busy),
      .done         (done),
      .result       (result)
   );

   limbSquarer limbSquarer_inst (
      .clk_sq       (clk_sq),
      .reset_sq     (reset_sq),
      .squareStart  (squareStart),
      .squareIn     (squareIn),
      .productValid (productValid),
      .product      (product)
   );

   foldReducer foldReducer_inst (
      .clk_sq       (clk_sq),
      .reset_sq     (reset_sq),
      .productValid (productValid),
      .product      (product),
      .residueValid (residueValid),
      .residue      (residue)
   );

endmodule

// ==== test/modSquareTop_sva.sv ====
// handshake checks for the squaring engine
// done shape, busy framing and result range

`timescale 1ns/10ps

module modSquareTop_sva (
   input logic                  clk_sq,
   input logic                  reset_sq,
   input logic                  start,
   input logic                  busy,
   input logic                  done,
   input modSquarePkg::residueT result
);

   import modSquarePkg::*;

   // done is a single-cycle strobe
   doneOneCycle: assert property (@(posedge clk_sq) disable iff (reset_sq)
      done |=> !done)
      else $error("done stayed high for more than one cycle");

   // done only after a running job or a start taken in the cycle before
   doneInsideJob: assert property (@(posedge clk_sq) disable iff (reset_sq)
      done |-> $past(busy || start))
      else $error("done raised without a running job or an accepted start");

   // fully reduced output
   resultBelowN: assert property (@(posedge clk_sq) disable iff (reset_sq)
      done |-> (result < modulusN))
      else $error("result not below the modulus at done");

   // busy ends only through the done cycle
   busyFallsWithDone: assert property (@(posedge clk_sq) disable iff (reset_sq)
      $fell(busy) |-> $past(done))
      else $error("busy dropped without a done pulse");

endmodule

bind modSquareTop modSquareTop_sva modSquareTop_sva_inst (
   .clk_sq   (clk_sq),
   .reset_sq (reset_sq),
   .start    (start),
   .busy     (busy),
   .done     (done),
   .result   (result)
);

// ==== test/modSquareTb.sv ====
// testbench for the modular squaring engine
// table of jobs checked against a repeated squaring model

`timescale 1ns/10ps

module modSquareTb;

   import modSquarePkg::*;

   localparam int clkPeriod   = 100;
   localparam int resetCycles = 8;
   localparam int randomRows  = 6;

   logic    clk_sq;
   logic    reset_sq;
   logic    start;
   residueT operand;
   countT   squarings;
   logic    busy;
   logic    done;
   residueT result;

   // job table: operand, count, expected result, second start while busy
   residueT rowOp [$];
   countT   rowCnt [$];
   residueT rowExp [$];
   bit      rowIntrude [$];

   int errorCount;
   int checkCount;
   int donePulses;
   int watchdogCycles = 0;

   modSquareTop modSquareTop_inst (
      .clk_sq    (clk_sq),
      .reset_sq  (reset_sq),
      .start     (start),
      .operand   (operand),
      .squarings (squarings),
      .busy      (busy),
      .done      (done),
      .result    (result)
   );

   initial
   begin
      clk_sq = 1'b0;
      forever
         #(clkPeriod / 2) clk_sq = ~clk_sq;
   end

   always @(negedge clk_sq)
   begin
      if (done === 1'b1)
         donePulses++;
   end

   // ----------------------------------------------------------
   // reference model and table
   // ----------------------------------------------------------
   // operand^(2^rounds) mod N, one wide squaring per round
   function automatic residueT squareModel(input residueT base, input countT rounds);
      longint unsigned x;
      x = 64'(base);
      for (int i = 0; i < int'(rounds); i++)
         x = (x * x) % 64'(modulusN);
      return residueT'(x);
   endfunction

   task automatic addRow(input residueT op, input countT cnt, input bit intrude);
      rowOp.push_back(op);
      rowCnt.push_back(cnt);
      rowExp.push_back(squareModel(op, cnt));
      rowIntrude.push_back(intrude);
   endtask

   task automatic buildTable();
      residueT op;
      countT   cnt;
      addRow(16'h1234, 8'd1, 1'b0);
      addRow(16'hBEEF, 8'd1, 1'b0);
      addRow(16'h7FFF, 8'd1, 1'b0);
      // edge operands
      addRow(16'h0000, 8'd1, 1'b0);
      addRow(16'h0001, 8'd1, 1'b0);
      addRow(modulusN - 16'd1, 8'd1, 1'b0);
      addRow(16'h00FF, 8'd1, 1'b0);
      addRow(16'hFF00, 8'd1, 1'b0);
      // repeated squaring, count 0 returns the operand
      addRow(16'h0003, 8'd0, 1'b0);
      addRow(16'hA5A5, 8'd2, 1'b0);
      addRow(16'h0003, 8'd17, 1'b0);
      addRow(16'hC0DE, 8'd255, 1'b0);
      addRow(16'h4321, 8'd3, 1'b1);
      for (int i = 0; i < randomRows; i++)
      begin
         op  = residueT'($urandom % 32'(modulusN));
         cnt = countT'(32'd1 + $urandom % 32'd8);
         addRow(op, cnt, 1'b0);
      end
   endtask

   // ----------------------------------------------------------
   // checks and job driver
   // ----------------------------------------------------------
   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      checkCount++;
      assert (got === expected)
      else
      begin
         $display("[FAIL] %0t %s: got %0h expected %0h", $time, name, got, expected);
         errorCount++;
      end
   endtask

   task automatic checkIdle(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk_sq);
         checkValue("busy", 32'(busy), 32'd0);
         checkValue("done", 32'(done), 32'd0);
      end
   endtask

   task automatic runJob(input residueT op, input countT cnt, input bit intrude,
                         input residueT expected);
      int limit;
      int cycles;
      int pulsesBefore;
      bit seen;
      limit        = int'(cnt) * 8 + 3;
      cycles       = 0;
      seen         = 1'b0;
      pulsesBefore = donePulses;
      start        = 1'b1;
      operand      = op;
      squarings    = cnt;
      @(negedge clk_sq);
      start = 1'b0;
      checkValue("busy", 32'(busy), 32'd1);
      while (!seen && cycles < limit)
      begin
         if (done === 1'b1)
            seen = 1'b1;
         else
         begin
            // a second job offered mid-run has to be dropped
            if (intrude && cycles == 2)
            begin
               start     = 1'b1;
               operand   = 16'h0002;
               squarings = 8'd3;
            end
            else
               start = 1'b0;
            @(negedge clk_sq);
            cycles++;
         end
      end
      start = 1'b0;
      checkCount++;
      assert (seen)
      else
      begin
         $display("no done for operand %h with %0d squarings within %0d cycles",
                  op, cnt, limit);
         errorCount++;
      end
      if (seen)
         checkValue("result", 32'(result), 32'(expected));
      @(negedge clk_sq);
      checkValue("busy", 32'(busy), 32'd0);
      repeat (2) @(negedge clk_sq);
      checkValue("result", 32'(result), 32'(expected));
      checkValue("done pulse count", 32'(donePulses - pulsesBefore), 32'd1);
   endtask

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial
   begin
      int    errorsBefore;
      string verdict;
      errorCount = 0;
      checkCount = 0;
      donePulses = 0;
      reset_sq   = 1'b1;
      start      = 1'b0;
      operand    = '0;
      squarings  = '0;
      void'($urandom(32582));
      buildTable();
      foreach (rowCnt[i])
         watchdogCycles += int'(rowCnt[i]) * 8 + 20;
      watchdogCycles += resetCycles;
      repeat (resetCycles) @(negedge clk_sq);
      reset_sq = 1'b0;
      checkIdle(3);
      for (int i = 0; i < rowOp.size(); i++)
      begin
         errorsBefore = errorCount;
         runJob(rowOp[i], rowCnt[i], rowIntrude[i], rowExp[i]);
         verdict = (errorCount == errorsBefore) ? "ok" : "failed";
         $display("test %0d: operand %h squarings %0d result %h expected %h %s",
                  i, rowOp[i], rowCnt[i], result, rowExp[i], verdict);
      end
      $display("%0d tests, %0d checks, %0d errors", rowOp.size(), checkCount, errorCount);
      if (errorCount == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // budget grows with the table
   initial
   begin
      wait (watchdogCycles > 0);
      #(watchdogCycles * clkPeriod);
      $display("watchdog expired after %0d cycles, the jobs did not finish", watchdogCycles);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/modSquarePkg.sv
rtl/limbSquarer.sv
rtl/foldReducer.sv
rtl/squareSequencer.sv
rtl/modSquareTop.sv
test/modSquareTop_sva.sv
test/modSquareTb.sv

// ==== Makefile ====
# Verilator build and run for the modular squaring engine

VERILATOR ?= verilator
TOP       ?= modSquareTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
